// File: flist.f
tanimoto_pkg.sv
popcount.sv
id_fifo.sv
threshold_table.sv
stream_ctrl.sv
similarity_lane.sv
match_arbiter.sv
tanimoto_top.sv
tanimoto_checker.sv
tb_tanimoto.sv

// File: run.sh
#!/bin/sh
# Build and run the Tanimoto screening testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_tanimoto -o sim_tanimoto
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tanimoto)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: tb_tanimoto.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tanimoto;
    import tanimoto_pkg::*;

    // Threshold table contents
    localparam int THR_ZERO = 0;
    localparam int THR_HALF = 1;
    localparam int THR_SELF = 2;
    localparam int THR_ALL  = 3;

    // Where the compare vectors come from
    localparam int CMP_RAND       = 0;
    localparam int CMP_SELF       = 1;
    localparam int CMP_ZERO_FIRST = 2;

    localparam int NUM_ROWS = 6;
    localparam int MAX_CMP  = 16;
    localparam int CMP_GAP  = 3;
    localparam int DRAIN    = 20;

    typedef struct packed {
        int                              mode;
        int                              cmp_kind;
        logic [NUM_REF-1:0][VEC_W-1:0]   refs;
        int                              num_cmp;
        int                              stall;
    } row_t;

    logic                  clk;
    logic                  rstn;
    vec_t                  i_vec;
    logic                  i_valid;
    logic                  i_thr_we;
    logic [THR_ADDR_W-1:0] i_thr_addr;
    sum_t                  i_thr_data;
    logic                  i_pair_read;
    logic                  o_pair_valid;
    pair_t                 o_pair;

    row_t rows [NUM_ROWS];
    vec_t cmp_vecs [MAX_CMP];
    int   exp_hits [NUM_REF][MAX_CMP];
    int   got_hits [NUM_REF][MAX_CMP];
    int   n_exp;
    int   n_got;
    int   n_stray;
    int   cur_cmp;
    int   n_checks;
    int   n_errors;
    int   cycle;
    int   cycle_limit;
    int   assert_fails;

    tanimoto_top tanimoto_top_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_vec        (i_vec),
        .i_valid      (i_valid),
        .i_thr_we     (i_thr_we),
        .i_thr_addr   (i_thr_addr),
        .i_thr_data   (i_thr_data),
        .i_pair_read  (i_pair_read),
        .o_pair_valid (o_pair_valid),
        .o_pair       (o_pair)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // Pairs are taken at the falling edge, the pop happens at the next rising edge
    always @(negedge clk) begin
        int rid;
        int cid;
        if (rstn && o_pair_valid && i_pair_read) begin
            rid = int'(o_pair[2*ID_W-1:ID_W]);
            cid = int'(o_pair[ID_W-1:0]);
            n_got = n_got + 1;
            if (rid < NUM_REF && cid < cur_cmp) begin
                got_hits[rid][cid] = got_hits[rid][cid] + 1;
            end else begin
                n_stray = n_stray + 1;
            end
        end
    end

    function automatic int count_ones(input logic [VEC_W-1:0] v);
        int n;
        n = 0;
        for (int b = 0; b < VEC_W; b++) begin
            n = n + int'(v[b]);
        end
        return n;
    endfunction

    // Largest weight sum that still matches for an AND count c
    function automatic int max_sum(input int mode, input int c);
        case (mode)
            THR_HALF: return 3 * c;
            THR_SELF: return 2 * c;
            THR_ALL:  return 64;
            default:  return 0;
        endcase
    endfunction

    function automatic row_t make_row(input int mode, input int kind,
                                      input vec_t r0, input vec_t r1,
                                      input vec_t r2, input vec_t r3,
                                      input int num_cmp, input int stall);
        row_t row;
        row.mode     = mode;
        row.cmp_kind = kind;
        row.refs[0]  = r0;
        row.refs[1]  = r1;
        row.refs[2]  = r2;
        row.refs[3]  = r3;
        row.num_cmp  = num_cmp;
        row.stall    = stall;
        return row;
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        n_checks = n_checks + 1;
        if (got != exp) begin
            n_errors = n_errors + 1;
            $display("CHECK FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        rstn     = 1'b0;
        i_valid  = 1'b0;
        i_thr_we = 1'b0;
        repeat (5) next_cycle();
        rstn = 1'b1;
    endtask

    task automatic write_table(input int mode);
        for (int c = 0; c < THR_ENTRIES; c++) begin
            i_thr_we   = 1'b1;
            i_thr_addr = THR_ADDR_W'(c);
            i_thr_data = sum_t'(max_sum(mode, c));
            next_cycle();
        end
        i_thr_we = 1'b0;
    endtask

    task automatic send_vector(input vec_t v);
        i_vec   = v;
        i_valid = 1'b1;
        next_cycle();
        i_valid = 1'b0;
    endtask

    // Compare vectors and the expected pair set from the match rule
    task automatic build_model(input int r);
        int c;
        int s;
        n_exp = 0;
        for (int j = 0; j < rows[r].num_cmp; j++) begin
            case (rows[r].cmp_kind)
                CMP_SELF:       cmp_vecs[j] = rows[r].refs[j % NUM_REF];
                CMP_ZERO_FIRST: cmp_vecs[j] = (j == 0) ? '0 : ($urandom() | 32'h1);
                default:        cmp_vecs[j] = $urandom();
            endcase
        end
        for (int k = 0; k < NUM_REF; k++) begin
            for (int j = 0; j < rows[r].num_cmp; j++) begin
                c = count_ones(rows[r].refs[k] & cmp_vecs[j]);
                s = count_ones(rows[r].refs[k]) + count_ones(cmp_vecs[j]);
                exp_hits[k][j] = (s <= max_sum(rows[r].mode, c)) ? 1 : 0;
                n_exp = n_exp + exp_hits[k][j];
            end
        end
    endtask

    task automatic run_row(input int r);
        int errs_before;
        errs_before = n_errors;
        build_model(r);
        for (int k = 0; k < NUM_REF; k++) begin
            for (int j = 0; j < MAX_CMP; j++) begin
                got_hits[k][j] = 0;
            end
        end
        n_got   = 0;
        n_stray = 0;
        cur_cmp = rows[r].num_cmp;
        apply_reset();
        repeat (3) begin
            next_cycle();
            check_value("o_pair_valid after reset", int'(o_pair_valid), 0);
        end
        // A zero table is what reset leaves behind
        if (rows[r].mode != THR_ZERO) begin
            write_table(rows[r].mode);
        end
        i_pair_read = (rows[r].stall == 0);
        for (int k = 0; k < NUM_REF; k++) begin
            send_vector(rows[r].refs[k]);
        end
        for (int j = 0; j < rows[r].num_cmp; j++) begin
            send_vector(cmp_vecs[j]);
            repeat (CMP_GAP) next_cycle();
        end
        if (rows[r].stall > 0) begin
            repeat (rows[r].stall) next_cycle();
            check_value("pairs held during read stall", int'(o_pair_valid), (n_exp > 0) ? 1 : 0);
            i_pair_read = 1'b1;
        end
        while (n_got < n_exp) begin
            next_cycle();
        end
        // Extra time so that duplicates would show up
        repeat (DRAIN) next_cycle();
        check_value("pairs collected", n_got, n_exp);
        check_value("pairs with unknown IDs", n_stray, 0);
        for (int k = 0; k < NUM_REF; k++) begin
            for (int j = 0; j < rows[r].num_cmp; j++) begin
                check_value($sformatf("pair (%0d, %0d)", k, j), got_hits[k][j], exp_hits[k][j]);
            end
        end
        if (rows[r].cmp_kind == CMP_SELF) begin
            for (int k = 0; k < NUM_REF && k < rows[r].num_cmp; k++) begin
                check_value($sformatf("self pair (%0d, %0d)", k, k), got_hits[k][k], 1);
            end
        end
        $display("Row %0d: %0d pairs expected, %0d collected, %0s", r, n_exp, n_got,
                 (n_errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        void'($urandom(32'h5acf));
        rstn         = 1'b0;
        i_vec        = '0;
        i_valid      = 1'b0;
        i_thr_we     = 1'b0;
        i_thr_addr   = '0;
        i_thr_data   = '0;
        i_pair_read  = 1'b0;
        cycle        = 0;
        n_checks     = 0;
        n_errors     = 0;
        n_got        = 0;
        n_stray      = 0;
        cur_cmp      = 0;

        rows[0] = make_row(THR_ZERO, CMP_RAND, 32'h0000_00ff, 32'h0f0f_0f0f,
                           32'hffff_0000, 32'h8000_0001, 0, 0);
        rows[1] = make_row(THR_HALF, CMP_RAND, 32'hffff_fff0, 32'h0ff0_ffff,
                           32'ha5a5_a5a5, 32'hffff_ffff, 12, 0);
        rows[2] = make_row(THR_SELF, CMP_SELF, 32'h1234_5678, 32'h0000_0001,
                           32'hdead_beef, 32'h8000_0000, 4, 0);
        rows[3] = make_row(THR_ALL, CMP_RAND, 32'h0000_0000, 32'hffff_ffff,
                           32'h5555_5555, 32'h00ff_ff00, 6, 0);
        rows[4] = make_row(THR_ALL, CMP_RAND, 32'h0f0f_f0f0, 32'h3c3c_3c3c,
                           32'h0000_0001, 32'hffff_fffe, 3, 40);
        rows[5] = make_row(THR_ZERO, CMP_ZERO_FIRST, 32'h0000_ff00, 32'h0000_0001,
                           32'h0000_0000, 32'hf000_0000, 5, 0);

        cycle_limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit = cycle_limit + 200 + 50 * rows[r].num_cmp;
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        assert_fails = tanimoto_top_i.tanimoto_checker_i.fail_count;
        $display("Summary: %0d rows, %0d checks, %0d check errors, %0d assertion failures",
                 NUM_ROWS, n_checks, n_errors, assert_fails);
        if (n_errors == 0 && assert_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tanimoto_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tanimoto_checker (
    input wire                              clk,
    input wire                              rstn,
    input wire                              i_pair_read,
    input wire                              i_pair_valid,
    input wire tanimoto_pkg::pair_t         i_pair,
    input wire [tanimoto_pkg::NUM_REF-1:0]  i_lane_pop,
    input wire [tanimoto_pkg::NUM_REF-1:0]  i_lane_empty
);
    import tanimoto_pkg::*;

    int fail_count = 0;

    // Output FIFO leaves reset empty
    valid_after_reset: assert property (@(posedge clk) !rstn |=> !i_pair_valid)
        else begin
            fail_count++;
            $error("o_pair_valid high right after reset");
        end

    // Head stays put until it is read
    pair_held: assert property (@(posedge clk) disable iff (!rstn)
        (i_pair_valid && !i_pair_read) |=> (i_pair_valid && $stable(i_pair)))
        else begin
            fail_count++;
            $error("o_pair changed or vanished while not read");
        end

    ref_id_range: assert property (@(posedge clk) disable iff (!rstn)
        i_pair_valid |-> (i_pair[2*ID_W-1:ID_W] < ID_W'(NUM_REF)))
        else begin
            fail_count++;
            $error("ref ID out of range in o_pair");
        end

    pop_not_empty: assert property (@(posedge clk) disable iff (!rstn)
        (i_lane_pop & i_lane_empty) == '0)
        else begin
            fail_count++;
            $error("lane FIFO popped while empty");
        end

endmodule

bind tanimoto_top tanimoto_checker tanimoto_checker_i (
    .clk          (clk),
    .rstn         (rstn),
    .i_pair_read  (i_pair_read),
    .i_pair_valid (o_pair_valid),
    .i_pair       (o_pair),
    .i_lane_pop   (lane_pop),
    .i_lane_empty (lane_empty)
);

`default_nettype wire

// File: tanimoto_top.sv
`timescale 1ns/1ps
`default_nettype none

module tanimoto_top (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire tanimoto_pkg::vec_t            i_vec,
    input  wire                                i_valid,
    input  wire                                i_thr_we,
    input  wire [tanimoto_pkg::THR_ADDR_W-1:0] i_thr_addr,
    input  wire tanimoto_pkg::sum_t            i_thr_data,
    input  wire                                i_pair_read,
    output logic                               o_pair_valid,
    output tanimoto_pkg::pair_t                o_pair
);
    import tanimoto_pkg::*;

    // Reference load bus
    logic               ref_load;
    logic [NUM_REF-1:0] ref_sel;
    vec_t               ref_vec;
    cnt_t               ref_cnt;
    id_t                ref_id;

    // Compare broadcast bus
    logic               cmp_valid;
    vec_t               cmp_vec;
    cnt_t               cmp_cnt;
    id_t                cmp_id;

    cnt_t                  lane_thr_addr [NUM_REF];
    sum_t                  lane_thr_data [NUM_REF];
    logic [NUM_REF-1:0]    lane_empty;
    logic [NUM_REF-1:0]    lane_pop;
    logic [FIFO_CNT_W-1:0] lane_count [NUM_REF];
    pair_t                 lane_pair  [NUM_REF];

    stream_ctrl stream_ctrl_i (
        .clk         (clk),
        .rstn        (rstn),
        .i_vec       (i_vec),
        .i_valid     (i_valid),
        .o_ref_load  (ref_load),
        .o_ref_sel   (ref_sel),
        .o_ref_vec   (ref_vec),
        .o_ref_cnt   (ref_cnt),
        .o_ref_id    (ref_id),
        .o_cmp_valid (cmp_valid),
        .o_cmp_vec   (cmp_vec),
        .o_cmp_cnt   (cmp_cnt),
        .o_cmp_id    (cmp_id)
    );

    threshold_table threshold_table_i (
        .clk        (clk),
        .rstn       (rstn),
        .i_thr_we   (i_thr_we),
        .i_thr_addr (i_thr_addr),
        .i_thr_data (i_thr_data),
        .i_rd_addr  (lane_thr_addr),
        .o_rd_data  (lane_thr_data)
    );

    for (genvar k = 0; k < NUM_REF; k++) begin : g_lane
        // Each lane takes only the reference addressed to it
        similarity_lane lane_i (
            .clk         (clk),
            .rstn        (rstn),
            .i_ref_load  (ref_load && ref_sel[k]),
            .i_ref_vec   (ref_vec),
            .i_ref_cnt   (ref_cnt),
            .i_ref_id    (ref_id),
            .i_cmp_valid (cmp_valid),
            .i_cmp_vec   (cmp_vec),
            .i_cmp_cnt   (cmp_cnt),
            .i_cmp_id    (cmp_id),
            .o_thr_addr  (lane_thr_addr[k]),
            .i_thr_data  (lane_thr_data[k]),
            .i_pop       (lane_pop[k]),
            .o_empty     (lane_empty[k]),
            .o_count     (lane_count[k]),
            .o_pair      (lane_pair[k])
        );
    end

    match_arbiter match_arbiter_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_lane_empty (lane_empty),
        .i_lane_count (lane_count),
        .i_lane_pair  (lane_pair),
        .o_lane_pop   (lane_pop),
        .i_pair_read  (i_pair_read),
        .o_pair_valid (o_pair_valid),
        .o_pair       (o_pair)
    );

endmodule

`default_nettype wire

// File: match_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module match_arbiter (
    input  wire                                  clk,
    input  wire                                  rstn,
    input  wire [tanimoto_pkg::NUM_REF-1:0]      i_lane_empty,
    input  wire [tanimoto_pkg::FIFO_CNT_W-1:0]   i_lane_count [tanimoto_pkg::NUM_REF],
    input  wire tanimoto_pkg::pair_t             i_lane_pair  [tanimoto_pkg::NUM_REF],
    output logic [tanimoto_pkg::NUM_REF-1:0]     o_lane_pop,
    input  wire                                  i_pair_read,
    output logic                                 o_pair_valid,
    output tanimoto_pkg::pair_t                  o_pair
);
    import tanimoto_pkg::*;

    logic [LANE_W-1:0]     sel;
    logic                  found;
    logic [FIFO_CNT_W-1:0] best_cnt;
    logic                  grant;
    logic                  out_full;
    logic                  out_empty;

    // Fullest non-empty lane wins, strict compare keeps the lowest index on ties
    always_comb begin
        sel      = '0;
        found    = 1'b0;
        best_cnt = '0;
        for (int k = 0; k < NUM_REF; k++) begin
            if (!i_lane_empty[k] && (!found || (i_lane_count[k] > best_cnt))) begin
                sel      = LANE_W'(k);
                found    = 1'b1;
                best_cnt = i_lane_count[k];
            end
        end
    end

    // At most one transfer per cycle, only while the output FIFO has room
    assign grant = found && !out_full;

    always_comb begin
        o_lane_pop = '0;
        if (grant) begin
            o_lane_pop[sel] = 1'b1;
        end
    end

    id_fifo out_fifo_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_push  (grant),
        .i_data  (i_lane_pair[sel]),
        .i_pop   (i_pair_read),
        .o_data  (o_pair),
        .o_empty (out_empty),
        .o_full  (out_full),
        .o_count ()
    );

    assign o_pair_valid = !out_empty;

endmodule

`default_nettype wire

// File: similarity_lane.sv
`timescale 1ns/1ps
`default_nettype none

module similarity_lane (
    input  wire                                  clk,
    input  wire                                  rstn,
    input  wire                                  i_ref_load,
    input  wire tanimoto_pkg::vec_t              i_ref_vec,
    input  wire tanimoto_pkg::cnt_t              i_ref_cnt,
    input  wire tanimoto_pkg::id_t               i_ref_id,
    input  wire                                  i_cmp_valid,
    input  wire tanimoto_pkg::vec_t              i_cmp_vec,
    input  wire tanimoto_pkg::cnt_t              i_cmp_cnt,
    input  wire tanimoto_pkg::id_t               i_cmp_id,
    output tanimoto_pkg::cnt_t                   o_thr_addr,
    input  wire tanimoto_pkg::sum_t              i_thr_data,
    input  wire                                  i_pop,
    output logic                                 o_empty,
    output logic [tanimoto_pkg::FIFO_CNT_W-1:0]  o_count,
    output tanimoto_pkg::pair_t                  o_pair
);
    import tanimoto_pkg::*;

    vec_t  ref_vec_q;
    cnt_t  ref_cnt_q;
    id_t   ref_id_q;
    sum_t  sum_pipe [POP_DELAY];
    id_t   cid_pipe [POP_DELAY];
    cnt_t  and_cnt;
    logic  and_valid;
    logic  match_q;
    pair_t pair_q;

    // Reference slot
    always_ff @(posedge clk) begin
        if (i_ref_load) begin
            ref_vec_q <= i_ref_vec;
            ref_cnt_q <= i_ref_cnt;
            ref_id_q  <= i_ref_id;
        end
    end

    // c = CNT(ref & cmp)
    popcount and_pop_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_vec   (ref_vec_q & i_cmp_vec),
        .i_valid (i_cmp_valid),
        .o_cnt   (and_cnt),
        .o_valid (and_valid)
    );

    // Weight sum and compare ID follow c through the popcount
    always_ff @(posedge clk) begin
        sum_pipe[0] <= sum_t'(ref_cnt_q) + sum_t'(i_cmp_cnt);
        cid_pipe[0] <= i_cmp_id;
        for (int s = 1; s < POP_DELAY; s++) begin
            sum_pipe[s] <= sum_pipe[s-1];
            cid_pipe[s] <= cid_pipe[s-1];
        end
    end

    assign o_thr_addr = and_cnt;

    // Registered threshold test
    always_ff @(posedge clk) begin
        if (!rstn) begin
            match_q <= 1'b0;
        end else begin
            match_q <= and_valid && (sum_pipe[POP_DELAY-1] <= i_thr_data);
        end
    end

    always_ff @(posedge clk) begin
        pair_q <= {ref_id_q, cid_pipe[POP_DELAY-1]};
    end

    id_fifo match_fifo_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_push  (match_q),
        .i_data  (pair_q),
        .i_pop   (i_pop),
        .o_data  (o_pair),
        .o_empty (o_empty),
        .o_full  (),
        .o_count (o_count)
    );

endmodule

`default_nettype wire

// File: stream_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module stream_ctrl (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire tanimoto_pkg::vec_t            i_vec,
    input  wire                                i_valid,
    output logic                               o_ref_load,
    output logic [tanimoto_pkg::NUM_REF-1:0]   o_ref_sel,
    output tanimoto_pkg::vec_t                 o_ref_vec,
    output tanimoto_pkg::cnt_t                 o_ref_cnt,
    output tanimoto_pkg::id_t                  o_ref_id,
    output logic                               o_cmp_valid,
    output tanimoto_pkg::vec_t                 o_cmp_vec,
    output tanimoto_pkg::cnt_t                 o_cmp_cnt,
    output tanimoto_pkg::id_t                  o_cmp_id
);
    import tanimoto_pkg::*;

    state_e state_q;
    id_t    id_q;
    logic   last_ref;
    vec_t   vec_pipe   [POP_DELAY];
    state_e state_pipe [POP_DELAY];
    id_t    id_pipe    [POP_DELAY];
    cnt_t   pop_cnt;
    logic   pop_valid;

    // The NUM_REF-th accepted vector ends the reference load
    assign last_ref = i_valid && (state_q == LOAD_REF) && (id_q == id_t'(NUM_REF - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= LOAD_REF;
            id_q    <= '0;
        end else if (last_ref) begin
            state_q <= COMPARE;
            id_q    <= '0;
        end else if (i_valid) begin
            id_q    <= id_q + 1'b1;
        end
    end

    // Input weight
    popcount in_pop_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_vec   (i_vec),
        .i_valid (i_valid),
        .o_cnt   (pop_cnt),
        .o_valid (pop_valid)
    );

    // Vector, state and ID ride alongside the popcount
    always_ff @(posedge clk) begin
        vec_pipe[0]   <= i_vec;
        state_pipe[0] <= state_q;
        id_pipe[0]    <= id_q;
        for (int s = 1; s < POP_DELAY; s++) begin
            vec_pipe[s]   <= vec_pipe[s-1];
            state_pipe[s] <= state_pipe[s-1];
            id_pipe[s]    <= id_pipe[s-1];
        end
    end

    assign o_ref_load  = pop_valid && (state_pipe[POP_DELAY-1] == LOAD_REF);
    assign o_ref_sel   = NUM_REF'(1) << id_pipe[POP_DELAY-1];
    assign o_ref_vec   = vec_pipe[POP_DELAY-1];
    assign o_ref_cnt   = pop_cnt;
    assign o_ref_id    = id_pipe[POP_DELAY-1];

    assign o_cmp_valid = pop_valid && (state_pipe[POP_DELAY-1] == COMPARE);
    assign o_cmp_vec   = vec_pipe[POP_DELAY-1];
    assign o_cmp_cnt   = pop_cnt;
    assign o_cmp_id    = id_pipe[POP_DELAY-1];

endmodule

`default_nettype wire

// File: threshold_table.sv
`timescale 1ns/1ps
`default_nettype none

module threshold_table (
    input  wire                                   clk,
    input  wire                                   rstn,
    input  wire                                   i_thr_we,
    input  wire [tanimoto_pkg::THR_ADDR_W-1:0]    i_thr_addr,
    input  wire tanimoto_pkg::sum_t               i_thr_data,
    input  wire tanimoto_pkg::cnt_t               i_rd_addr [tanimoto_pkg::NUM_REF],
    output tanimoto_pkg::sum_t                    o_rd_data [tanimoto_pkg::NUM_REF]
);
    import tanimoto_pkg::*;

    sum_t thr_q [THR_ENTRIES];

    // Entry c holds the largest allowed CNT(ref) + CNT(cmp)
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int e = 0; e < THR_ENTRIES; e++) begin
                thr_q[e] <= '0;
            end
        end else if (i_thr_we && (i_thr_addr < THR_ADDR_W'(THR_ENTRIES))) begin
            thr_q[i_thr_addr] <= i_thr_data;
        end
    end

    // One combinational read port per lane
    always_comb begin
        for (int k = 0; k < NUM_REF; k++) begin
            o_rd_data[k] = thr_q[i_rd_addr[k]];
        end
    end

endmodule

`default_nettype wire

// File: id_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module id_fifo (
    input  wire                                  clk,
    input  wire                                  rstn,
    input  wire                                  i_push,
    input  wire tanimoto_pkg::pair_t             i_data,
    input  wire                                  i_pop,
    output tanimoto_pkg::pair_t                  o_data,
    output logic                                 o_empty,
    output logic                                 o_full,
    output logic [tanimoto_pkg::FIFO_CNT_W-1:0]  o_count
);
    import tanimoto_pkg::*;

    pair_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    assign o_empty = (count == '0);
    assign o_full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign o_count = count;

    // Overflow and underflow requests are dropped
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // First word falls through
    assign o_data = mem[rd_ptr];

endmodule

`default_nettype wire

// File: popcount.sv
`timescale 1ns/1ps
`default_nettype none

module popcount (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire tanimoto_pkg::vec_t  i_vec,
    input  wire                      i_valid,
    output tanimoto_pkg::cnt_t       o_cnt,
    output logic                     o_valid
);
    import tanimoto_pkg::*;

    logic [POP_PART_W-1:0] part_d [POP_GRPS];
    logic [POP_PART_W-1:0] part_q [POP_GRPS];
    logic                  part_valid;
    cnt_t                  total_d;

    // Stage one, one small adder per byte
    always_comb begin
        for (int g = 0; g < POP_GRPS; g++) begin
            part_d[g] = '0;
            for (int b = 0; b < POP_GRP_W; b++) begin
                part_d[g] = part_d[g] + POP_PART_W'(i_vec[g*POP_GRP_W + b]);
            end
        end
    end

    // Stage two adds the byte counts
    always_comb begin
        total_d = '0;
        for (int g = 0; g < POP_GRPS; g++) begin
            total_d = total_d + cnt_t'(part_q[g]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            part_valid <= 1'b0;
            o_valid    <= 1'b0;
        end else begin
            part_valid <= i_valid;
            o_valid    <= part_valid;
        end
    end

    always_ff @(posedge clk) begin
        part_q <= part_d;
        o_cnt  <= total_d;
    end

endmodule

`default_nettype wire

// File: tanimoto_pkg.sv
`default_nettype none

package tanimoto_pkg;

    // Vector and lane geometry
    localparam int VEC_W       = 32;
    localparam int NUM_REF     = 4;
    localparam int LANE_W      = $clog2(NUM_REF);
    localparam int ID_W        = 8;

    // Match FIFOs and the output FIFO share one size
    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = FIFO_PTR_W + 1;

    // Popcount splits the vector into byte groups
    localparam int POP_DELAY   = 2;
    localparam int POP_GRP_W   = 8;
    localparam int POP_GRPS    = VEC_W / POP_GRP_W;
    localparam int POP_PART_W  = $clog2(POP_GRP_W + 1);

    // One threshold entry per possible AND popcount
    localparam int THR_ENTRIES = VEC_W + 1;
    localparam int THR_ADDR_W  = 6;

    typedef logic [VEC_W-1:0]  vec_t;
    typedef logic [5:0]        cnt_t;
    typedef logic [6:0]        sum_t;
    typedef logic [ID_W-1:0]   id_t;
    // Ref ID in the upper byte, compare ID in the lower byte
    typedef logic [2*ID_W-1:0] pair_t;

    typedef enum logic {
        LOAD_REF = 1'b0,
        COMPARE  = 1'b1
    } state_e;

endpackage

`default_nettype wire
